// File: list.f
common/mipsPkg.sv
common/ctrlIf.sv
logic/aluUnit.sv
logic/regFile.sv
logic/mainControl.sv
logic/dataPath.sv
logic/multiCore.sv
test/multiCore_asserts.sv
test/multiCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the multicycle core testbench with Verilator
# Exit status is 0 only when the pass line appears in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module multiCoreTb -Mdir obj_dir
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

simOutput=$(./obj_dir/VmultiCoreTb +verilator+error+limit+1000)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOutput" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

// File: test/multiCoreTb.sv
//======================================================================
// Testbench for the multicycle core with a 256-word memory at address 0
// Operands at 0x200, results at 0x300, final store at 0x33c
// Memory answers reads combinationally and takes writes mid-cycle
//======================================================================
`timescale 1ns/100ps

module multiCoreTb;

	localparam int memWords = 256;
	localparam int numTests = 10;
	localparam int timeoutCycles = 2000;
	localparam logic [31:0] doneAddr = 32'h33c; // Last store of the program

	// MIPS32 encodings
	localparam logic [5:0] opR = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	logic iCLK;
	logic iRST;
	logic [31:0] initialPc;
	logic [31:0] memReadData;
	logic [31:0] memAddress;
	logic [31:0] memWriteData;
	logic memRead;
	logic memWrite;
	logic [31:0] pc;
	logic [31:0] mem [memWords];

	string testName [numTests];
	logic [31:0] testAddr [numTests];
	logic [31:0] testExp [numTests];
	bit testSeen [numTests];
	int passCount;
	int errorCount;
	bit doneSeen;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] copyWord;
	logic [15:0] imm;

	function automatic logic [31:0] rInst(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {opR, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] iInst(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm16);
		return {op, rs, rt, imm16};
	endfunction

	function automatic logic [31:0] jInst(input logic [25:0] target);
		return {opJ, target};
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < memWords; i++)
			mem[i] = 32'hbad00000 | 32'(i); // Illegal opcode, unique per word
		mem[0] = iInst(opLw, 5'd0, 5'd1, 16'h0200);
		mem[1] = iInst(opLw, 5'd0, 5'd2, 16'h0204);
		mem[2] = rInst(5'd1, 5'd2, 5'd3, fnAdd);
		mem[3] = iInst(opSw, 5'd0, 5'd3, 16'h0300);
		mem[4] = rInst(5'd1, 5'd2, 5'd4, fnSub);
		mem[5] = iInst(opSw, 5'd0, 5'd4, 16'h0304);
		mem[6] = rInst(5'd1, 5'd2, 5'd5, fnAnd);
		mem[7] = iInst(opSw, 5'd0, 5'd5, 16'h0308);
		mem[8] = rInst(5'd1, 5'd2, 5'd6, fnOr);
		mem[9] = iInst(opSw, 5'd0, 5'd6, 16'h030c);
		mem[10] = rInst(5'd1, 5'd2, 5'd7, fnSlt);
		mem[11] = iInst(opSw, 5'd0, 5'd7, 16'h0310);
		mem[12] = iInst(opAddi, 5'd1, 5'd8, imm);
		mem[13] = iInst(opSw, 5'd0, 5'd8, 16'h0314);
		mem[14] = iInst(opLw, 5'd0, 5'd9, 16'h0208); // Word copy
		mem[15] = iInst(opSw, 5'd0, 5'd9, 16'h0318);
		mem[16] = iInst(opAddi, 5'd1, 5'd0, imm); // Write to $zero
		mem[17] = iInst(opSw, 5'd0, 5'd0, 16'h031c);
		mem[18] = iInst(opBeq, 5'd1, 5'd1, 16'd1); // Taken, skips 19
		mem[19] = iInst(opSw, 5'd0, 5'd1, 16'h0320); // Wrong path
		mem[20] = iInst(opSw, 5'd0, 5'd1, 16'h0324);
		mem[21] = iInst(opBeq, 5'd1, 5'd10, 16'd2); // Not taken, $10 is zero
		mem[22] = iInst(opSw, 5'd0, 5'd2, 16'h0328);
		mem[23] = jInst(26'd25);
		mem[24] = iInst(opSw, 5'd0, 5'd2, 16'h032c); // Branch target, wrong path
		mem[25] = iInst(opSw, 5'd0, 5'd1, doneAddr[15:0]);
		mem[26] = jInst(26'd26); // Park
		mem[128] = opA;
		mem[129] = opB;
		mem[130] = copyWord;
	endtask

	task automatic setTest(input int idx, input string name, input logic [31:0] addr,
		input logic [31:0] value);
		testName[idx] = name;
		testAddr[idx] = addr;
		testExp[idx] = value;
		testSeen[idx] = 1'b0;
	endtask

	// Expected values from the instruction rules, 32-bit wraparound
	task automatic fillExpected();
		setTest(0, "add", 32'h300, opA + opB);
		setTest(1, "sub", 32'h304, opA - opB);
		setTest(2, "and", 32'h308, opA & opB);
		setTest(3, "or", 32'h30c, opA | opB);
		// Differing signs decide alone, equal signs compare magnitudes
		setTest(4, "slt", 32'h310, (opA[31] != opB[31]) ? {31'd0, opA[31]}
			: {31'd0, opA < opB});
		setTest(5, "addi", 32'h314, opA + (imm[15] ? {16'hffff, imm} : {16'h0000, imm}));
		setTest(6, "lwCopy", 32'h318, copyWord);
		setTest(7, "zeroReg", 32'h31c, 32'd0);
		setTest(8, "beqTaken", 32'h324, opA);
		setTest(9, "beqNotTaken", 32'h328, opB);
	endtask

	task automatic handleStore();
		int idx;
		idx = -1;
		for (int t = 0; t < numTests; t++)
			if (testAddr[t] == memAddress)
				idx = t;
		mem[memAddress[9:2]] = memWriteData;
		if (memAddress == doneAddr)
			doneSeen = 1'b1;
		else
		begin
			assert (idx >= 0)
			else
			begin
				$display("Store to %h is off the program path, wrong beq path taken", memAddress);
				errorCount++;
			end
			if (idx >= 0)
			begin
				testSeen[idx] = 1'b1;
				assert (memWriteData === testExp[idx])
				begin
					$display("[PASS] %s", testName[idx]);
					passCount++;
				end
				else
				begin
					$display("[FAIL] %s expected %h actual %h", testName[idx], testExp[idx],
						memWriteData);
					errorCount++;
				end
			end
		end
	endtask

	// One falling edge, bus sampled mid-cycle
	task automatic stepCycle();
		@(negedge iCLK);
		if (memWrite)
			handleStore();
	endtask

	always #20 iCLK = ~iCLK;

	assign memReadData = mem[memAddress[9:2]];

	multiCore multiCore_inst
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.initialPc(initialPc),
		.memReadData(memReadData),
		.memAddress(memAddress),
		.memWriteData(memWriteData),
		.memRead(memRead),
		.memWrite(memWrite),
		.pc(pc)
	);

	initial
	begin
		logic [31:0] randWord;
		int asrtFails;
		iCLK = 1'b0;
		iRST = 1'b1;
		initialPc = 32'd0;
		passCount = 0;
		errorCount = 0;
		doneSeen = 1'b0;
		void'($urandom(32'h223a03fa));
		opA = $urandom | 32'd1; // Nonzero so the second beq falls through
		opB = $urandom;
		copyWord = $urandom;
		randWord = $urandom;
		imm = randWord[15:0];
		loadProgram();
		fillExpected();
		repeat (5) stepCycle(); // Reset held five cycles
		iRST = 1'b0;
		for (int c = 0; c < timeoutCycles && !doneSeen; c++)
			stepCycle();
		assert (doneSeen)
		else
		begin
			$display("Timeout, program never reached its final store in %0d cycles",
				timeoutCycles);
			errorCount++;
		end
		repeat (2) stepCycle(); // Last store cycle reaches the bus checks
		for (int t = 0; t < numTests; t++)
		begin
			assert (testSeen[t])
			else
			begin
				$display("Test %s never stored its result", testName[t]);
				errorCount++;
			end
		end
		asrtFails = multiCore_inst.multiCoreAsserts_inst.failures;
		$display("Tests passed: %0d, errors: %0d, bus assertion failures: %0d", passCount,
			errorCount, asrtFails);
		if (errorCount == 0 && asrtFails == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: test/multiCore_asserts.sv
//======================================================================
// Bus and sequencing checks, bound into multiCore
// A fetch is a read whose address equals PC
// Program data must sit away from the instruction addresses
//======================================================================
`timescale 1ns/100ps

module multiCoreAsserts
(
	input logic iCLK,
	input logic iRST,
	input mipsPkg::word_t initialPc,
	input mipsPkg::word_t memReadData,
	input mipsPkg::word_t memAddress,
	input mipsPkg::word_t memWriteData,
	input logic memRead,
	input logic memWrite,
	input mipsPkg::word_t pc
);

	int failures = 0; // Read by the testbench at the end
	logic isFetch;
	logic [5:0] fetchOp;

	assign isFetch = memRead && (memAddress == pc);
	assign fetchOp = memReadData[31:26]; // Opcode of the word being fetched

	// Upper PC+4 bits, then the 26-bit target in words
	function automatic mipsPkg::word_t jumpDest(input mipsPkg::word_t addr,
		input mipsPkg::word_t inst);
		mipsPkg::word_t nextAddr;
		nextAddr = addr + 32'd4;
		return {nextAddr[31:28], inst[25:0], 2'b00};
	endfunction

	function automatic mipsPkg::word_t branchDest(input mipsPkg::word_t addr,
		input mipsPkg::word_t inst);
		return addr + 32'd4 + {{14{inst[15]}}, inst[15:0], 2'b00}; // Offset counts words
	endfunction

	// pc must match the bus address here, later fetches chain from this one
	firstFetch: assert property (@(posedge iCLK) $fell(iRST) |-> !memRead ##1
		(isFetch && memAddress == initialPc))
		else begin failures++; $error("First fetch after reset not at initialPc or pc wrong"); end

	noWriteInReset: assert property (@(posedge iCLK) iRST |-> !memWrite)
		else begin failures++; $error("memWrite high during reset"); end

	readWriteExclusive: assert property (@(posedge iCLK) disable iff (iRST)
		!(memRead && memWrite))
		else begin failures++; $error("memRead and memWrite high together"); end

	singleCycleWrite: assert property (@(posedge iCLK) disable iff (iRST)
		memWrite |=> !memWrite)
		else begin failures++; $error("memWrite high for two cycles in a row"); end

	// Stores are whole words with defined data
	cleanStore: assert property (@(posedge iCLK) disable iff (iRST)
		memWrite |-> (!$isunknown(memWriteData) && memAddress[1:0] == 2'b00))
		else begin failures++; $error("Store data unknown or address not word aligned"); end

	// R-type, addi and sw
	fourCycles: assert property (@(posedge iCLK) disable iff (iRST)
		isFetch && (fetchOp == 6'h00 || fetchOp == 6'h08 || fetchOp == 6'h2b)
		|=> !isFetch ##1 !isFetch ##1 !isFetch ##1 isFetch)
		else begin failures++; $error("R-type, addi or sw did not take 4 cycles"); end

	lwFiveCycles: assert property (@(posedge iCLK) disable iff (iRST)
		isFetch && fetchOp == 6'h23
		|=> !isFetch ##1 !isFetch ##1 !isFetch ##1 !isFetch ##1 isFetch)
		else begin failures++; $error("lw did not take 5 cycles"); end

	// Taken or fall through, path stores decide which one was right
	beqNext: assert property (@(posedge iCLK) disable iff (iRST)
		isFetch && fetchOp == 6'h04 |=> !isFetch ##1 !isFetch ##1 (isFetch &&
		(memAddress == $past(memAddress, 3) + 32'd4 ||
		memAddress == branchDest($past(memAddress, 3), $past(memReadData, 3)))))
		else begin failures++; $error("beq next fetch wrong or not after 3 cycles"); end

	jumpNext: assert property (@(posedge iCLK) disable iff (iRST)
		isFetch && fetchOp == 6'h02 |=> !isFetch ##1 !isFetch ##1 (isFetch &&
		memAddress == jumpDest($past(memAddress, 3), $past(memReadData, 3))))
		else begin failures++; $error("j next fetch wrong or not after 3 cycles"); end

endmodule

bind multiCore multiCoreAsserts multiCoreAsserts_inst
(
	.iCLK(iCLK),
	.iRST(iRST),
	.initialPc(initialPc),
	.memReadData(memReadData),
	.memAddress(memAddress),
	.memWriteData(memWriteData),
	.memRead(memRead),
	.memWrite(memWrite),
	.pc(pc)
);

// File: logic/multiCore.sv
//====================================================================
// Core top level, plain word-wide memory bus without handshake
// memReadData must be valid in the same cycle that memRead is high
//====================================================================
`timescale 1ns/100ps

module multiCore
(
	input  logic iCLK,
	input  logic iRST,
	input  mipsPkg::word_t initialPc,
	input  mipsPkg::word_t memReadData,
	output mipsPkg::word_t memAddress,
	output mipsPkg::word_t memWriteData,
	output logic memRead,
	output logic memWrite,
	output mipsPkg::word_t pc
);

	ctrlIf ctrlIf_inst (); // FSM to datapath strobes

	mainControl mainControl_inst
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.ctrl(ctrlIf_inst.ctrl),
		.memRead(memRead),
		.memWrite(memWrite)
	);

	dataPath dataPath_inst
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.initialPc(initialPc),
		.dp(ctrlIf_inst.dp),
		.memReadData(memReadData),
		.memAddress(memAddress),
		.memWriteData(memWriteData),
		.pc(pc)
	);

endmodule

// File: logic/dataPath.sv
//====================================================================
// Multicycle datapath with PC, IR, A, B, MDR and ALUOut
// A, B, MDR and ALUOut load every cycle, PC and IR only on strobes
// Word accesses only, address low bits pass to the bus unchanged
//====================================================================
`timescale 1ns/100ps

module dataPath
(
	input  logic iCLK,
	input  logic iRST,
	input  mipsPkg::word_t initialPc,
	ctrlIf.dp dp,
	input  mipsPkg::word_t memReadData,
	output mipsPkg::word_t memAddress,
	output mipsPkg::word_t memWriteData,
	output mipsPkg::word_t pc
);

	mipsPkg::word_t pcReg;
	mipsPkg::word_t ir;
	mipsPkg::word_t regA;
	mipsPkg::word_t regB;
	mipsPkg::word_t mdr;
	mipsPkg::word_t aluOut;
	mipsPkg::word_t readData1;
	mipsPkg::word_t readData2;
	mipsPkg::word_t aluInA;
	mipsPkg::word_t aluInB;
	mipsPkg::word_t aluResult;
	mipsPkg::word_t signImm;
	mipsPkg::word_t branchOffset;
	mipsPkg::word_t jumpTarget;
	mipsPkg::word_t nextPc;
	mipsPkg::word_t writeData;
	mipsPkg::regIdx_t writeReg;
	logic aluZero;

	// Instruction fields
	assign dp.opcode = mipsPkg::opcode_t'(ir[31:26]);
	assign dp.funct = mipsPkg::funct_t'(ir[5:0]);
	assign signImm = {{16{ir[15]}}, ir[15:0]};
	assign branchOffset = {{14{ir[15]}}, ir[15:0], 2'b00}; // Word offset to bytes
	assign jumpTarget = {pcReg[31:28], ir[25:0], 2'b00}; // pcReg already holds PC+4

	assign writeReg = dp.regDst ? ir[15:11] : ir[20:16]; // rd : rt
	assign writeData = dp.memToReg ? mdr : aluOut;
	assign aluInA = (dp.aluSrcA == mipsPkg::srcRegA) ? regA : pcReg;

	always_comb
	begin
		case (dp.aluSrcB)
			mipsPkg::srcRegB: aluInB = regB;
			mipsPkg::srcFour: aluInB = 32'd4;
			mipsPkg::srcImm: aluInB = signImm;
			default: aluInB = branchOffset; // srcBranchOffset
		endcase
	end

	always_comb
	begin
		case (dp.pcSource)
			mipsPkg::pcAluOut: nextPc = aluOut; // Branch target from decode
			mipsPkg::pcJump: nextPc = jumpTarget;
			default: nextPc = aluResult; // PC + 4 in fetch
		endcase
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pcReg <= initialPc;
			ir <= 32'd0;
			regA <= 32'd0;
			regB <= 32'd0;
			mdr <= 32'd0;
			aluOut <= 32'd0;
		end
		else
		begin
			regA <= readData1;
			regB <= readData2;
			mdr <= memReadData; // Meaningful only after a read cycle
			aluOut <= aluResult;
			if (dp.irWrite)
				ir <= memReadData;
			if (dp.pcWrite || (dp.branchEn && aluZero))
				pcReg <= nextPc; // beq taken when rs - rt is zero
		end
	end

	regFile regFile_inst
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.readReg1(ir[25:21]),
		.readReg2(ir[20:16]),
		.writeReg(writeReg),
		.writeData(writeData),
		.regWrite(dp.regWrite),
		.readData1(readData1),
		.readData2(readData2)
	);

	aluUnit aluUnit_inst
	(
		.a(aluInA),
		.b(aluInB),
		.op(dp.aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	assign memAddress = dp.iorD ? aluOut : pcReg;
	assign memWriteData = regB; // rt value from decode
	assign pc = pcReg;

endmodule

// File: logic/mainControl.sv
//====================================================================
// Multicycle control FSM, one state per cycle, strobes decoded from state
// Strobes stay low during reset and for the first cycle after it
// Unknown opcode or funct parks the FSM in illegal until reset
//====================================================================
`timescale 1ns/100ps

module mainControl
(
	input  logic iCLK,
	input  logic iRST,
	ctrlIf.ctrl ctrl,
	output logic memRead,
	output logic memWrite
);

	mipsPkg::ctrlState_t state;
	mipsPkg::ctrlState_t nextState;
	logic started; // Set one edge after reset falls

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state <= mipsPkg::fetch;
			started <= 1'b0;
		end
		else
		begin
			started <= 1'b1;
			if (started)
				state <= nextState; // Hold fetch until the FSM is running
		end
	end

	// Next state
	always_comb
	begin
		nextState = mipsPkg::illegal;
		case (state)
			mipsPkg::fetch: nextState = mipsPkg::decode;
			mipsPkg::decode:
			begin
				case (ctrl.opcode)
					mipsPkg::rType:
					begin
						case (ctrl.funct)
							mipsPkg::add, mipsPkg::sub, mipsPkg::andOp, mipsPkg::orOp,
							mipsPkg::slt: nextState = mipsPkg::execR;
							default: nextState = mipsPkg::illegal; // Unknown funct
						endcase
					end
					mipsPkg::addi: nextState = mipsPkg::execI;
					mipsPkg::lw, mipsPkg::sw: nextState = mipsPkg::memAddr;
					mipsPkg::beq: nextState = mipsPkg::branch;
					mipsPkg::j: nextState = mipsPkg::jump;
					default: nextState = mipsPkg::illegal;
				endcase
			end
			mipsPkg::memAddr: nextState = (ctrl.opcode == mipsPkg::lw) ? mipsPkg::memReadSt
				: mipsPkg::memWriteSt;
			mipsPkg::memReadSt: nextState = mipsPkg::memWriteBack;
			mipsPkg::execR, mipsPkg::execI: nextState = mipsPkg::aluWriteBack;
			mipsPkg::memWriteBack, mipsPkg::memWriteSt, mipsPkg::aluWriteBack,
			mipsPkg::branch, mipsPkg::jump: nextState = mipsPkg::fetch;
			default: nextState = mipsPkg::illegal; // Sticky
		endcase
	end

	// Strobes per state
	always_comb
	begin
		memRead = 1'b0;
		memWrite = 1'b0;
		ctrl.irWrite = 1'b0;
		ctrl.pcWrite = 1'b0;
		ctrl.branchEn = 1'b0;
		ctrl.iorD = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.regDst = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.aluSrcA = mipsPkg::srcPc;
		ctrl.aluSrcB = mipsPkg::srcRegB;
		ctrl.aluOp = mipsPkg::aluAdd;
		ctrl.pcSource = mipsPkg::pcAluResult;
		if (started)
		begin
			case (state)
				mipsPkg::fetch:
				begin
					memRead = 1'b1; // Bus address is PC
					ctrl.irWrite = 1'b1;
					ctrl.pcWrite = 1'b1;
					ctrl.aluSrcB = mipsPkg::srcFour; // PC + 4 straight into PC
				end
				mipsPkg::decode: ctrl.aluSrcB = mipsPkg::srcBranchOffset; // Target into ALUOut
				mipsPkg::memAddr:
				begin
					ctrl.aluSrcA = mipsPkg::srcRegA;
					ctrl.aluSrcB = mipsPkg::srcImm;
				end
				mipsPkg::memReadSt:
				begin
					memRead = 1'b1;
					ctrl.iorD = 1'b1; // MDR captures the word
				end
				mipsPkg::memWriteBack:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.memToReg = 1'b1; // MDR into rt
				end
				mipsPkg::memWriteSt:
				begin
					memWrite = 1'b1; // Single cycle, B at ALUOut
					ctrl.iorD = 1'b1;
				end
				mipsPkg::execR:
				begin
					ctrl.aluSrcA = mipsPkg::srcRegA;
					case (ctrl.funct)
						mipsPkg::sub: ctrl.aluOp = mipsPkg::aluSub;
						mipsPkg::andOp: ctrl.aluOp = mipsPkg::aluAnd;
						mipsPkg::orOp: ctrl.aluOp = mipsPkg::aluOr;
						mipsPkg::slt: ctrl.aluOp = mipsPkg::aluSlt;
						default: ctrl.aluOp = mipsPkg::aluAdd;
					endcase
				end
				mipsPkg::execI:
				begin
					ctrl.aluSrcA = mipsPkg::srcRegA;
					ctrl.aluSrcB = mipsPkg::srcImm;
				end
				mipsPkg::aluWriteBack:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.regDst = (ctrl.opcode == mipsPkg::rType); // rd for R-type, rt for addi
				end
				mipsPkg::branch:
				begin
					ctrl.aluSrcA = mipsPkg::srcRegA;
					ctrl.aluOp = mipsPkg::aluSub; // Zero when A equals B
					ctrl.branchEn = 1'b1;
					ctrl.pcSource = mipsPkg::pcAluOut;
				end
				mipsPkg::jump:
				begin
					ctrl.pcWrite = 1'b1;
					ctrl.pcSource = mipsPkg::pcJump;
				end
				default: ; // illegal, everything low
			endcase
		end
	end

endmodule

// File: logic/regFile.sv
//====================================================================
// 32 x 32 register file, two async read ports, one sync write port
// Register 0 reads as zero, all registers clear on reset
//====================================================================
`timescale 1ns/100ps

module regFile
(
	input  logic iCLK,
	input  logic iRST,
	input  mipsPkg::regIdx_t readReg1,
	input  mipsPkg::regIdx_t readReg2,
	input  mipsPkg::regIdx_t writeReg,
	input  mipsPkg::word_t writeData,
	input  logic regWrite,
	output mipsPkg::word_t readData1,
	output mipsPkg::word_t readData2
);

	mipsPkg::word_t regs [32];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end
		else if (regWrite && (writeReg != 5'd0))
			regs[writeReg] <= writeData; // $zero never written
	end

	assign readData1 = regs[readReg1]; // rs
	assign readData2 = regs[readReg2]; // rt

endmodule

// File: logic/aluUnit.sv
//====================================================================
// 32-bit integer ALU, purely combinational
// No overflow detection, add and sub wrap around
//====================================================================
`timescale 1ns/100ps

module aluUnit
(
	input  mipsPkg::word_t a,
	input  mipsPkg::word_t b,
	input  mipsPkg::aluOp_t op,
	output mipsPkg::word_t result,
	output logic zero
);

	always_comb
	begin
		case (op)
			mipsPkg::aluAdd: result = a + b;
			mipsPkg::aluSub: result = a - b;
			mipsPkg::aluAnd: result = a & b;
			mipsPkg::aluOr: result = a | b;
			mipsPkg::aluSlt:
			begin
				// Signed compare, result is 0 or 1
				result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			end
			default: result = 32'd0;
		endcase
	end

	// Used by beq after a subtract
	assign zero = (result == 32'd0);

endmodule

// File: common/ctrlIf.sv
//====================================================================
// Control strobes from the FSM to the datapath, decoded IR fields back
// opcode and funct may carry codes outside their enums
//====================================================================
`timescale 1ns/100ps

interface ctrlIf;

	logic irWrite; // Load IR from memory
	logic pcWrite; // Unconditional PC update
	logic branchEn; // PC update only when ALU zero
	logic iorD; // 0 = PC, 1 = ALUOut on the bus
	logic memToReg; // Write back MDR instead of ALUOut
	logic regDst; // rd instead of rt
	logic regWrite;
	mipsPkg::aluSrcA_t aluSrcA;
	mipsPkg::aluSrcB_t aluSrcB;
	mipsPkg::aluOp_t aluOp;
	mipsPkg::pcSource_t pcSource;

	mipsPkg::opcode_t opcode; // IR[31:26]
	mipsPkg::funct_t funct; // IR[5:0]

	modport ctrl
	(
		output irWrite, pcWrite, branchEn, iorD, memToReg, regDst, regWrite,
		output aluSrcA, aluSrcB, aluOp, pcSource,
		input opcode, funct
	);

	modport dp
	(
		input irWrite, pcWrite, branchEn, iorD, memToReg, regDst, regWrite,
		input aluSrcA, aluSrcB, aluOp, pcSource,
		output opcode, funct
	);

endinterface

// File: common/mipsPkg.sv
//====================================================================
// Shared types for the multicycle MIPS subset core
// Opcode and funct values follow the standard MIPS32 encodings
// Only the word-wide integer subset is encoded here
//====================================================================
package mipsPkg;

	typedef logic [31:0] word_t; // Data, address or instruction
	typedef logic [4:0] regIdx_t; // Register number

	// Primary opcode, IR[31:26]
	typedef enum logic [5:0]
	{
		rType = 6'h00,
		j     = 6'h02,
		beq   = 6'h04,
		addi  = 6'h08,
		lw    = 6'h23,
		sw    = 6'h2b
	} opcode_t;

	// R-type funct, IR[5:0]
	typedef enum logic [5:0]
	{
		add   = 6'h20,
		sub   = 6'h22,
		andOp = 6'h24,
		orOp  = 6'h25,
		slt   = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_t;

	typedef enum logic {srcPc, srcRegA} aluSrcA_t;
	typedef enum logic [1:0] {srcRegB, srcFour, srcImm, srcBranchOffset} aluSrcB_t;
	typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJump} pcSource_t; // 2'd3 unused

	// One state per clock cycle
	typedef enum logic [3:0]
	{
		fetch, decode, memAddr, memReadSt, memWriteBack, memWriteSt,
		execR, execI, aluWriteBack, branch, jump, illegal
	} ctrlState_t;

endpackage
